// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_booth_mult_unit
FILELIST  = booth_mult_unit.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== booth/booth_multiplier.sv ====
`default_nettype none

module booth_multiplier (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     empty,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   head_a,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   head_b,
    output logic                                    pop,
    output logic                                    result_valid,
    output logic signed [booth_pkg::PRODUCT_W-1:0]  result,
    output logic                                    busy
);

    // busy doubles as the controller state (0 idle, 1 compute)

    logic [booth_pkg::STEP_CNT_W-1:0] step_cnt;
    logic                             last_step_done;

    // multiplicand carries a guard bit so that -32768 never overflows the upper half
    logic signed [booth_pkg::OPERAND_W:0] mcand;

    // {partial product (guard + 16), multiplier (16)}
    logic signed [booth_pkg::PRODUCT_W:0] acc;
    logic                                 prev;   // bit shifted out last step

    logic signed [booth_pkg::OPERAND_W:0] upper;
    logic signed [booth_pkg::OPERAND_W:0] upper_next;
    logic signed [booth_pkg::PRODUCT_W:0] acc_next;

    assign pop = ~busy & ~empty;

    assign last_step_done =
        (step_cnt == (booth_pkg::STEP_CNT_W)'(booth_pkg::BOOTH_STEPS));

    assign upper = $signed(acc[booth_pkg::PRODUCT_W:booth_pkg::OPERAND_W]);

    // radix-2 recoding on {q0, q-1}
    always_comb begin
        case ({acc[0], prev})
            2'b10: upper_next = upper - mcand;
            2'b01: upper_next = upper + mcand;
            default: upper_next = upper;
        endcase
    end

    // arithmetic shift right of the whole register
    assign acc_next = {upper_next[booth_pkg::OPERAND_W],
                       upper_next,
                       acc[booth_pkg::OPERAND_W-1:1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
        end else if (!busy) begin
            if (pop) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end
        end else if (last_step_done) begin
            busy <= 1'b0;   // result registered at this same edge
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (pop) begin
            mcand <= {head_a[booth_pkg::OPERAND_W-1], head_a};
            acc   <= {{(booth_pkg::OPERAND_W + 1){1'b0}}, head_b};
            prev  <= 1'b0;
        end else if (busy && !last_step_done) begin
            acc  <= acc_next;
            prev <= acc[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= busy & last_step_done; // one cycle pulse
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (busy && last_step_done) begin
            // low 32 bits hold the full signed product
            result <= $signed(acc[booth_pkg::PRODUCT_W-1:0]);
        end
    end

endmodule

`default_nettype wire

// ==== booth_mult_unit.f ====
+incdir+sim
common/booth_pkg.sv
logic/operand_issue.sv
logic/operand_fifo.sv
booth/booth_multiplier.sv
logic/booth_mult_unit.sv
sim/tb_booth_mult_unit.sv

// ==== common/booth_pkg.sv ====
`default_nettype none

package booth_pkg;

    // operand and product widths
    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 32;

    // one radix-2 step per multiplier bit
    localparam int BOOTH_STEPS = 16;
    localparam int STEP_CNT_W  = 5; // must hold BOOTH_STEPS itself

    // operand queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    localparam int ACCEPT_CNT_W = 16; // wraps

endpackage

`default_nettype wire

// ==== logic/booth_mult_unit.sv ====
`default_nettype none

module booth_mult_unit (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     in_valid,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   in_a,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   in_b,
    output logic                                    in_ready,
    output logic                                    result_valid,
    output logic signed [booth_pkg::PRODUCT_W-1:0]  result,
    output logic                                    busy,
    output logic                                    overflow,
    output logic [booth_pkg::ACCEPT_CNT_W-1:0]      accepted_count
);

    // staging to fifo
    logic                                   push;
    logic signed [booth_pkg::OPERAND_W-1:0] push_a;
    logic signed [booth_pkg::OPERAND_W-1:0] push_b;
    logic                                   full;

    // fifo to multiplier
    logic                                   pop;
    logic                                   empty;
    logic signed [booth_pkg::OPERAND_W-1:0] head_a;
    logic signed [booth_pkg::OPERAND_W-1:0] head_b;

    operand_issue operand_issue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_a           (in_a),
        .in_b           (in_b),
        .full           (full),
        .in_ready       (in_ready),
        .push           (push),
        .push_a         (push_a),
        .push_b         (push_b),
        .overflow       (overflow),
        .accepted_count (accepted_count)
    );

    operand_fifo operand_fifo_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .push   (push),
        .push_a (push_a),
        .push_b (push_b),
        .pop    (pop),
        .head_a (head_a),
        .head_b (head_b),
        .full   (full),
        .empty  (empty)
    );

    booth_multiplier booth_multiplier_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .empty        (empty),
        .head_a       (head_a),
        .head_b       (head_b),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result),
        .busy         (busy)
    );

endmodule

`default_nettype wire

// ==== logic/operand_fifo.sv ====
`default_nettype none

module operand_fifo (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     push,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   push_a,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   push_b,
    input  wire                                     pop,
    output logic signed [booth_pkg::OPERAND_W-1:0]  head_a,
    output logic signed [booth_pkg::OPERAND_W-1:0]  head_b,
    output logic                                    full,
    output logic                                    empty
);

    logic signed [booth_pkg::OPERAND_W-1:0] mem_a [booth_pkg::FIFO_DEPTH];
    logic signed [booth_pkg::OPERAND_W-1:0] mem_b [booth_pkg::FIFO_DEPTH];

    logic [booth_pkg::FIFO_AW-1:0] wr_ptr;
    logic [booth_pkg::FIFO_AW-1:0] rd_ptr;
    logic [booth_pkg::FIFO_AW:0]   count;   // one extra bit to tell full from empty

    // show-ahead head
    assign head_a = mem_a[rd_ptr];
    assign head_b = mem_b[rd_ptr];

    assign full  = (count == (booth_pkg::FIFO_AW + 1)'(booth_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem_a[wr_ptr] <= push_a;
            mem_b[wr_ptr] <= push_b;
        end
    end

    // pointers wrap on their own with a power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
        // push and pop together leave the count alone
    end

endmodule

`default_nettype wire

// ==== logic/operand_issue.sv ====
`default_nettype none

module operand_issue (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire                                     in_valid,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   in_a,
    input  wire signed [booth_pkg::OPERAND_W-1:0]   in_b,
    input  wire                                     full,
    output logic                                    in_ready,
    output logic                                    push,
    output logic signed [booth_pkg::OPERAND_W-1:0]  push_a,
    output logic signed [booth_pkg::OPERAND_W-1:0]  push_b,
    output logic                                    overflow,
    output logic [booth_pkg::ACCEPT_CNT_W-1:0]      accepted_count
);

    logic                                   staged;  // staging register occupied
    logic signed [booth_pkg::OPERAND_W-1:0] stage_a;
    logic signed [booth_pkg::OPERAND_W-1:0] stage_b;
    logic                                   accept;
    logic                                   drop;

    assign in_ready = ~staged;
    assign accept   = in_valid & ~staged;
    assign drop     = in_valid & staged;   // strobe with nowhere to go

    // forward the staged pair as soon as the fifo has room
    assign push   = staged & ~full;
    assign push_a = stage_a;
    assign push_b = stage_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            staged <= 1'b0;
        end else if (accept) begin
            staged <= 1'b1;
        end else if (push) begin
            staged <= 1'b0;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (accept) begin
            stage_a <= in_a;
            stage_b <= in_b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (drop) begin
            overflow <= 1'b1; // sticky until reset
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accepted_count <= '0;
        end else if (accept) begin
            accepted_count <= accepted_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_booth_checks.svh ====
`ifndef TB_BOOTH_CHECKS_SVH
`define TB_BOOTH_CHECKS_SVH

int check_count = 0;
int error_count = 0;
int test_count  = 0;

// x or z on either side counts as a mismatch
task automatic check_value(
    input string             name,
    input logic signed [63:0] expected,
    input logic signed [63:0] actual
);
    check_count++;
    if (expected !== actual) begin
        error_count++;
        $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic report_error(input string name, input string msg);
    error_count++;
    $display("ERROR in %s: %s", name, msg);
endtask

// one line per finished test
task automatic report_test(input string name, input int errors_before);
    int errors;
    errors = error_count - errors_before;
    test_count++;
    if (errors == 0) begin
        $display("test %s done, no errors", name);
    end else begin
        $display("test %s done, %0d errors", name, errors);
    end
endtask

task automatic print_summary();
    $display("summary: %0d tests, %0d checks, %0d errors",
             test_count, check_count, error_count);
endtask

`endif

// ==== sim/tb_booth_mult_unit.sv ====
`default_nettype none

module tb_booth_mult_unit;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int RANDOM_PAIRS    = 200;
    localparam int CORNER_PAIRS    = 16;
    localparam int BURST_CYCLES    = 40;
    localparam int CYCLES_PER_PAIR = 18;
    localparam int TOTAL_PAIRS     = RANDOM_PAIRS + CORNER_PAIRS + 1 + BURST_CYCLES;
    localparam int TIMEOUT_CYCLES  = TOTAL_PAIRS * CYCLES_PER_PAIR + 500;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   in_valid;
    logic signed [booth_pkg::OPERAND_W-1:0] in_a;
    logic signed [booth_pkg::OPERAND_W-1:0] in_b;
    logic                                   in_ready;
    logic                                   result_valid;
    logic signed [booth_pkg::PRODUCT_W-1:0] result;
    logic                                   busy;
    logic                                   overflow;
    logic [booth_pkg::ACCEPT_CNT_W-1:0]     accepted_count;

    // reference model state
    logic [2*booth_pkg::OPERAND_W-1:0] pending_q [$];  // {a, b} in acceptance order
    logic [2*booth_pkg::OPERAND_W-1:0] monitor_pair;
    int    accepted_total = 0;
    int    dropped_total  = 0;
    int    results_total  = 0;
    string test_name      = "reset_state";

    `include "tb_booth_checks.svh"

    booth_mult_unit booth_mult_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_a           (in_a),
        .in_b           (in_b),
        .in_ready       (in_ready),
        .result_valid   (result_valid),
        .result         (result),
        .busy           (busy),
        .overflow       (overflow),
        .accepted_count (accepted_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles, DUT stopped responding", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic signed [booth_pkg::PRODUCT_W-1:0] model_product(
        input logic signed [booth_pkg::OPERAND_W-1:0] a,
        input logic signed [booth_pkg::OPERAND_W-1:0] b
    );
        logic signed [booth_pkg::PRODUCT_W-1:0] wide_a;
        logic signed [booth_pkg::PRODUCT_W-1:0] wide_b;
        wide_a = a;   // sign extends
        wide_b = b;
        return wide_a * wide_b;
    endfunction

    // sampled mid-cycle where inputs and outputs are stable
    always @(negedge clk) begin
        if (rst_n) begin
            check_value({test_name, " overflow"}, 64'(dropped_total != 0), 64'(overflow));
            if (in_valid) begin
                if (in_ready) begin
                    pending_q.push_back({in_a, in_b}); // captured at next edge
                    accepted_total++;
                end else begin
                    dropped_total++;
                end
            end
            if (result_valid) begin
                results_total++;
                if (pending_q.size() == 0) begin
                    report_error(test_name, "result_valid pulsed with no pair pending");
                end else begin
                    monitor_pair = pending_q.pop_front();
                    check_value({test_name, " product"},
                                64'(model_product(monitor_pair[31:16], monitor_pair[15:0])),
                                64'(result));
                end
            end
        end
    end

    // one strobe once in_ready is seen high
    task automatic send_pair(input logic [15:0] a, input logic [15:0] b);
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b1;
        in_a     <= a;
        in_b     <= b;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (pending_q.size() != 0 || busy || !in_ready || in_valid) @(negedge clk);
    endtask

    task automatic check_counts(input int accepted_before, input int results_before);
        check_value({test_name, " result count"},
                    64'(accepted_total - accepted_before),
                    64'(results_total - results_before));
        check_value({test_name, " accepted_count"},
                    64'(accepted_total % (1 << booth_pkg::ACCEPT_CNT_W)),
                    64'(accepted_count));
    endtask

    task automatic run_reset_test();
        int errors_before;
        errors_before = error_count;
        test_name = "reset_state";
        @(negedge clk);
        check_value({test_name, " result_valid"}, 64'(0), 64'(result_valid));
        check_value({test_name, " busy"}, 64'(0), 64'(busy));
        check_value({test_name, " overflow"}, 64'(0), 64'(overflow));
        check_value({test_name, " result"}, 64'(0), 64'(result));
        check_value({test_name, " accepted_count"}, 64'(0), 64'(accepted_count));
        check_value({test_name, " in_ready"}, 64'(1), 64'(in_ready));
        report_test(test_name, errors_before);
    endtask

    task automatic run_random_test();
        int          errors_before;
        int          accepted_before;
        int          results_before;
        logic [31:0] rand_word;
        int          gap;
        errors_before   = error_count;
        accepted_before = accepted_total;
        results_before  = results_total;
        test_name = "random_products";
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            rand_word = $urandom();
            gap       = $urandom_range(2, 0);
            send_pair(rand_word[15:0], rand_word[31:16]);
            repeat (gap) @(posedge clk);
        end
        wait_drain();
        check_counts(accepted_before, results_before);
        report_test(test_name, errors_before);
    endtask

    task automatic run_corner_test();
        int          errors_before;
        logic [15:0] list_a [CORNER_PAIRS];
        logic [15:0] list_b [CORNER_PAIRS];
        errors_before = error_count;
        test_name = "corner_operands";
        list_a = '{16'h8000, 16'h8000, 16'h7fff, 16'h0000, 16'h1234, 16'h0001,
                   16'h5a5a, 16'hffff, 16'ha5a5, 16'h7fff, 16'hffff, 16'h8000,
                   16'hffff, 16'h8000, 16'h0000, 16'h0001};
        list_b = '{16'h8000, 16'h7fff, 16'h8000, 16'ha5a5, 16'h0000, 16'hc3c3,
                   16'h0001, 16'h3c3c, 16'hffff, 16'h7fff, 16'hffff, 16'hffff,
                   16'h8000, 16'h0001, 16'h0000, 16'hffff};
        for (int i = 0; i < CORNER_PAIRS; i++) begin
            send_pair(list_a[i], list_b[i]);
        end
        wait_drain();
        report_test(test_name, errors_before);
    endtask

    task automatic run_latency_test();
        int errors_before;
        int waited;
        int cycles;
        errors_before = error_count;
        test_name = "latency_busy";
        wait_drain();
        send_pair(16'h0123, 16'hfba9);
        waited = 0;
        @(negedge clk);
        while (!busy && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (!busy) begin
            report_error(test_name, "busy never rose after the pair was sent");
        end else begin
            cycles = 0;
            while (!result_valid && cycles < 40) begin
                check_value({test_name, " busy held"}, 64'(1), 64'(busy));
                @(negedge clk);
                cycles++;
            end
            check_value({test_name, " cycles"}, 64'(17), 64'(cycles));
            check_value({test_name, " busy at result"}, 64'(0), 64'(busy));
        end
        wait_drain();
        report_test(test_name, errors_before);
    endtask

    task automatic run_burst_test();
        int          errors_before;
        int          accepted_before;
        int          results_before;
        logic [31:0] rand_word;
        errors_before   = error_count;
        accepted_before = accepted_total;
        results_before  = results_total;
        test_name = "burst_overflow";
        for (int i = 0; i < BURST_CYCLES; i++) begin
            rand_word = $urandom();
            @(posedge clk);
            in_valid <= 1'b1;
            in_a     <= rand_word[15:0];
            in_b     <= rand_word[31:16];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait_drain();
        check_counts(accepted_before, results_before);
        // fifo and staging cannot absorb 40 strobes
        check_value({test_name, " overflow set"}, 64'(1), 64'(overflow));
        report_test(test_name, errors_before);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;
        void'($urandom(22990));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        run_reset_test();
        run_random_test();
        run_corner_test();
        run_latency_test();
        run_burst_test();
        print_summary();
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
